/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_dcache
OBJ_DIR   ?= obj_dir
FILELIST  ?= build.f
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* build.f */
cache_pkg.sv
mem_bus_pkg.sv
dcache_controller.sv
dcache_mem.sv
mshr_table.sv
dcache_top.sv
tb_clock.sv
tb_mem_model.sv
tb_dcache.sv

/* cache_pkg.sv */
`default_nettype none

package cache_pkg;

    localparam int ADDR_BITS = 16;
    localparam int SET_BITS  = 5;
    localparam int TAG_BITS  = ADDR_BITS - SET_BITS;

    // word address with the tag above the set index
    typedef struct packed {
        logic [TAG_BITS-1:0] tag;
        logic [SET_BITS-1:0] set;
    } word_addr_t;

    typedef logic [63:0] data_word_t;

    typedef struct packed {
        logic       rd_en;
        logic       wr_en;
        word_addr_t rd_addr;
        word_addr_t wr_addr;
        data_word_t wr_data;
    } proc_req_t;

    // ready means the miss table can take another entry
    typedef struct packed {
        data_word_t data;
        logic       valid_data;
        logic       ready;
    } proc_resp_t;

    typedef struct packed {
        logic       en;
        word_addr_t addr;
        data_word_t data;
        logic       dirty;
        logic       from_mem;
    } array_wr_t;

    // current contents of the set on the write port
    typedef struct packed {
        logic       valid;
        logic       dirty;
        word_addr_t addr;
        data_word_t data;
    } victim_t;

endpackage

`default_nettype wire

/* dcache_controller.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_controller (
    input  cache_pkg::proc_req_t    proc_req,
    output cache_pkg::proc_resp_t   proc_resp,
    input  cache_pkg::data_word_t   rd_data,
    input  logic                    rd_hit,
    input  logic                    wr_hit,
    input  cache_pkg::victim_t      victim,
    output cache_pkg::word_addr_t   arr_rd_addr,
    output cache_pkg::array_wr_t    arr_wr,
    input  logic                    pend_hit_rd,
    input  logic                    pend_hit_wr,
    input  mem_bus_pkg::fill_t      fill,
    input  logic                    mshr_ready,
    output cache_pkg::word_addr_t   search_rd_addr,
    output cache_pkg::word_addr_t   search_wr_addr,
    output mem_bus_pkg::miss_req_t  miss_rd,
    output mem_bus_pkg::miss_req_t  miss_wr,
    output mem_bus_pkg::miss_req_t  miss_evict,
    output logic                    fill_taken_load,
    output logic                    fill_taken_store,
    output logic                    fill_taken_mem
);
    import cache_pkg::*;
    import mem_bus_pkg::*;

    logic fill_taken;

    // read side straight from the array
    assign arr_rd_addr          = proc_req.rd_addr;
    assign proc_resp.data       = rd_data;
    assign proc_resp.valid_data = proc_req.rd_en & rd_hit;
    assign proc_resp.ready      = mshr_ready;

    assign search_rd_addr = proc_req.rd_addr;
    assign search_wr_addr = proc_req.wr_addr;

    // write port goes to the store first, then read-miss, store-miss and plain fills
    always_comb begin
        arr_wr           = '0;
        fill_taken_load  = 1'b0;
        fill_taken_store = 1'b0;
        fill_taken_mem   = 1'b0;
        if (proc_req.wr_en) begin
            // array drops the write itself when the store misses
            arr_wr.en       = 1'b1;
            arr_wr.addr     = proc_req.wr_addr;
            arr_wr.data     = proc_req.wr_data;
            arr_wr.dirty    = 1'b1;
            arr_wr.from_mem = 1'b0;
        end else if (fill.valid) begin
            arr_wr.en       = 1'b1;
            arr_wr.addr     = fill.addr;
            arr_wr.data     = fill.data;
            arr_wr.dirty    = fill.dirty;
            arr_wr.from_mem = 1'b1;
            if (fill.kind == LOAD && proc_req.rd_en && fill.addr == proc_req.rd_addr) begin
                fill_taken_load = 1'b1;
            end else if (fill.kind == STORE) begin
                fill_taken_store = 1'b1;
            end else begin
                // nobody is waiting on this line right now
                fill_taken_mem = 1'b1;
            end
        end
    end

    assign fill_taken = fill_taken_load | fill_taken_store | fill_taken_mem;

    // store miss that the table merges when the address is already pending
    assign miss_wr.en   = proc_req.wr_en & ~wr_hit;
    assign miss_wr.addr = proc_req.wr_addr;
    assign miss_wr.data = proc_req.wr_data;
    assign miss_wr.kind = STORE;

    // a store miss to the same word covers the read, so the read waits
    assign miss_rd.en   = proc_req.rd_en & ~rd_hit & ~pend_hit_rd &
                          ~(miss_wr.en & (proc_req.wr_addr == proc_req.rd_addr));
    assign miss_rd.addr = proc_req.rd_addr;
    assign miss_rd.data = '0;
    assign miss_rd.kind = LOAD;

    // fill landing on a dirty line of another tag pushes the old word out
    assign miss_evict.en   = fill_taken & victim.valid & victim.dirty &
                             (victim.addr.tag != fill.addr.tag);
    assign miss_evict.addr = victim.addr;
    assign miss_evict.data = victim.data;
    assign miss_evict.kind = EVICT;

endmodule

`default_nettype wire

/* dcache_mem.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_mem (
    input  logic                  clock,
    input  logic                  rst_n,
    input  cache_pkg::word_addr_t rd_addr,
    input  cache_pkg::array_wr_t  wr,
    output cache_pkg::data_word_t rd_data,
    output logic                  rd_hit,
    output logic                  wr_hit,
    output cache_pkg::victim_t    victim
);
    import cache_pkg::*;

    localparam int NUM_SETS = 1 << SET_BITS;

    data_word_t          data_q  [NUM_SETS];
    logic [TAG_BITS-1:0] tag_q   [NUM_SETS];
    logic [NUM_SETS-1:0] valid_q;
    logic [NUM_SETS-1:0] dirty_q;
    logic                wr_do;

    assign rd_data = data_q[rd_addr.set];
    assign rd_hit  = valid_q[rd_addr.set] & (tag_q[rd_addr.set] == rd_addr.tag);
    assign wr_hit  = valid_q[wr.addr.set] & (tag_q[wr.addr.set] == wr.addr.tag);

    // whatever the write port set holds right now
    assign victim.valid    = valid_q[wr.addr.set];
    assign victim.dirty    = dirty_q[wr.addr.set];
    assign victim.addr.tag = tag_q[wr.addr.set];
    assign victim.addr.set = wr.addr.set;
    assign victim.data     = data_q[wr.addr.set];

    // fills always write, processor stores only on a hit
    assign wr_do = wr.en & (wr.from_mem | wr_hit);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (wr_do) begin
            valid_q[wr.addr.set] <= 1'b1;
            dirty_q[wr.addr.set] <= wr.dirty;
        end
    end

    always_ff @(posedge clock) begin
        if (wr_do) begin
            data_q[wr.addr.set] <= wr.data;
            // tag only changes when a new line is brought in
            if (wr.from_mem) begin
                tag_q[wr.addr.set] <= wr.addr.tag;
            end
        end
    end

endmodule

`default_nettype wire

/* dcache_top.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_top #(
    parameter int MSHR_DEPTH = 4
) (
    input  logic                   clock,
    input  logic                   rst_n,
    input  cache_pkg::proc_req_t   proc_req,
    output cache_pkg::proc_resp_t  proc_resp,
    output mem_bus_pkg::mem_req_t  mem_req,
    input  mem_bus_pkg::mem_tag_t  mem_grant_tag,
    input  mem_bus_pkg::mem_resp_t mem_resp
);
    import cache_pkg::*;
    import mem_bus_pkg::*;

    word_addr_t arr_rd_addr;
    array_wr_t  arr_wr;
    data_word_t rd_data;
    logic       rd_hit;
    logic       wr_hit;
    victim_t    victim;
    word_addr_t search_rd_addr;
    word_addr_t search_wr_addr;
    miss_req_t  miss_rd;
    miss_req_t  miss_wr;
    miss_req_t  miss_evict;
    logic       pend_hit_rd;
    logic       pend_hit_wr;
    fill_t      fill;
    logic       mshr_ready;
    logic       fill_taken_load;
    logic       fill_taken_store;
    logic       fill_taken_mem;

    dcache_controller u_ctrl (
        .proc_req         (proc_req),
        .proc_resp        (proc_resp),
        .rd_data          (rd_data),
        .rd_hit           (rd_hit),
        .wr_hit           (wr_hit),
        .victim           (victim),
        .arr_rd_addr      (arr_rd_addr),
        .arr_wr           (arr_wr),
        .pend_hit_rd      (pend_hit_rd),
        .pend_hit_wr      (pend_hit_wr),
        .fill             (fill),
        .mshr_ready       (mshr_ready),
        .search_rd_addr   (search_rd_addr),
        .search_wr_addr   (search_wr_addr),
        .miss_rd          (miss_rd),
        .miss_wr          (miss_wr),
        .miss_evict       (miss_evict),
        .fill_taken_load  (fill_taken_load),
        .fill_taken_store (fill_taken_store),
        .fill_taken_mem   (fill_taken_mem)
    );

    dcache_mem u_mem (
        .clock   (clock),
        .rst_n   (rst_n),
        .rd_addr (arr_rd_addr),
        .wr      (arr_wr),
        .rd_data (rd_data),
        .rd_hit  (rd_hit),
        .wr_hit  (wr_hit),
        .victim  (victim)
    );

    mshr_table #(
        .MSHR_DEPTH (MSHR_DEPTH)
    ) u_mshr (
        .clock            (clock),
        .rst_n            (rst_n),
        .search_rd_addr   (search_rd_addr),
        .search_wr_addr   (search_wr_addr),
        .miss_rd          (miss_rd),
        .miss_wr          (miss_wr),
        .miss_evict       (miss_evict),
        .store_data       (proc_req.wr_data),
        .fill_taken_load  (fill_taken_load),
        .fill_taken_store (fill_taken_store),
        .fill_taken_mem   (fill_taken_mem),
        .mem_grant_tag    (mem_grant_tag),
        .mem_resp         (mem_resp),
        .pend_hit_rd      (pend_hit_rd),
        .pend_hit_wr      (pend_hit_wr),
        .fill             (fill),
        .mem_req          (mem_req),
        .ready            (mshr_ready)
    );

endmodule

`default_nettype wire

/* mem_bus_pkg.sv */
`default_nettype none

package mem_bus_pkg;

    typedef enum logic [1:0] {
        BUS_NONE  = 2'd0,
        BUS_LOAD  = 2'd1,
        BUS_STORE = 2'd2
    } bus_cmd_e;

    typedef enum logic [1:0] {
        LOAD  = 2'd0,
        STORE = 2'd1,
        EVICT = 2'd2
    } miss_kind_e;

    // tag 0 is reserved for "no response"
    typedef logic [3:0] mem_tag_t;

    typedef struct packed {
        bus_cmd_e              cmd;
        cache_pkg::word_addr_t addr;
        cache_pkg::data_word_t data;
    } mem_req_t;

    typedef struct packed {
        mem_tag_t              tag;
        cache_pkg::data_word_t data;
    } mem_resp_t;

    // one per source for read miss, store miss and eviction
    typedef struct packed {
        logic                  en;
        cache_pkg::word_addr_t addr;
        cache_pkg::data_word_t data;
        miss_kind_e            kind;
    } miss_req_t;

    // offer from the miss table to the array write port
    typedef struct packed {
        logic                  valid;
        miss_kind_e            kind;
        cache_pkg::word_addr_t addr;
        cache_pkg::data_word_t data;
        logic                  dirty;
    } fill_t;

endpackage

`default_nettype wire

/* mshr_table.sv */
`timescale 1ns/1ns
`default_nettype none

module mshr_table #(
    parameter int MSHR_DEPTH = 4
) (
    input  logic                   clock,
    input  logic                   rst_n,
    input  cache_pkg::word_addr_t  search_rd_addr,
    input  cache_pkg::word_addr_t  search_wr_addr,
    input  mem_bus_pkg::miss_req_t miss_rd,
    input  mem_bus_pkg::miss_req_t miss_wr,
    input  mem_bus_pkg::miss_req_t miss_evict,
    input  cache_pkg::data_word_t  store_data,
    input  logic                   fill_taken_load,
    input  logic                   fill_taken_store,
    input  logic                   fill_taken_mem,
    input  mem_bus_pkg::mem_tag_t  mem_grant_tag,
    input  mem_bus_pkg::mem_resp_t mem_resp,
    output logic                   pend_hit_rd,
    output logic                   pend_hit_wr,
    output mem_bus_pkg::fill_t     fill,
    output mem_bus_pkg::mem_req_t  mem_req,
    output logic                   ready
);
    import cache_pkg::*;
    import mem_bus_pkg::*;

    localparam int IDX_BITS = (MSHR_DEPTH > 1) ? $clog2(MSHR_DEPTH) : 1;
    localparam int CNT_BITS = $clog2(MSHR_DEPTH + 1);

    typedef struct packed {
        logic       valid;
        word_addr_t addr;
        miss_kind_e kind;
        logic       issued;
        mem_tag_t   tag;
        logic       data_ready;
        data_word_t data;
        logic       dirty;
    } entry_t;

    entry_t                ent [MSHR_DEPTH];
    logic [7:0]            age [MSHR_DEPTH];
    logic [MSHR_DEPTH-1:0] hit_rd;
    logic [MSHR_DEPTH-1:0] hit_wr;
    logic [CNT_BITS-1:0]   free_cnt;
    logic [IDX_BITS-1:0]   free_lo;
    logic [IDX_BITS-1:0]   free_hi;
    logic                  any_free;
    logic                  issue_vld;
    logic [IDX_BITS-1:0]   issue_idx;
    logic                  fill_vld;
    logic [IDX_BITS-1:0]   fill_idx;
    logic                  fill_taken;
    logic                  merge;
    logic                  alloc_wr;
    logic                  alloc_rd;

    function automatic entry_t make_entry(miss_req_t req);
        entry_t e;
        e            = '0;
        e.valid      = 1'b1;
        e.addr       = req.addr;
        e.kind       = req.kind;
        e.data       = req.data;
        e.dirty      = (req.kind != LOAD);
        return e;
    endfunction

    always_comb begin
        free_cnt = '0;
        free_lo  = '0;
        free_hi  = '0;
        any_free = 1'b0;
        for (int i = 0; i < MSHR_DEPTH; i++) begin
            hit_rd[i] = ent[i].valid & (ent[i].addr == search_rd_addr);
            hit_wr[i] = ent[i].valid & (ent[i].addr == search_wr_addr);
            if (!ent[i].valid) begin
                if (!any_free) begin
                    free_lo = IDX_BITS'(i);
                end
                free_hi  = IDX_BITS'(i);
                any_free = 1'b1;
                free_cnt = free_cnt + 1'b1;
            end
        end
    end

    assign pend_hit_rd = |hit_rd;
    assign pend_hit_wr = |hit_wr;
    // room for a read miss, a store miss and an eviction in one cycle
    assign ready       = (free_cnt >= CNT_BITS'(3));

    // evictions go out first, then the lowest waiting miss
    always_comb begin
        logic found_evict;
        found_evict = 1'b0;
        issue_vld   = 1'b0;
        issue_idx   = '0;
        for (int i = 0; i < MSHR_DEPTH; i++) begin
            if (ent[i].valid && !ent[i].issued) begin
                if (ent[i].kind == EVICT && !found_evict) begin
                    found_evict = 1'b1;
                    issue_vld   = 1'b1;
                    issue_idx   = IDX_BITS'(i);
                end else if (!issue_vld) begin
                    issue_vld = 1'b1;
                    issue_idx = IDX_BITS'(i);
                end
            end
        end
    end

    always_comb begin
        mem_req     = '0;
        mem_req.cmd = BUS_NONE;
        if (issue_vld) begin
            mem_req.cmd  = (ent[issue_idx].kind == EVICT) ? BUS_STORE : BUS_LOAD;
            mem_req.addr = ent[issue_idx].addr;
            mem_req.data = ent[issue_idx].data;
        end
    end

    // oldest entry with data in hand
    always_comb begin
        logic [7:0] best_age;
        best_age = '0;
        fill_vld = 1'b0;
        fill_idx = '0;
        for (int i = 0; i < MSHR_DEPTH; i++) begin
            if (ent[i].valid && ent[i].data_ready && (!fill_vld || age[i] > best_age)) begin
                fill_vld = 1'b1;
                fill_idx = IDX_BITS'(i);
                best_age = age[i];
            end
        end
    end

    assign fill.valid = fill_vld;
    assign fill.kind  = ent[fill_idx].kind;
    assign fill.addr  = ent[fill_idx].addr;
    assign fill.data  = ent[fill_idx].data;
    assign fill.dirty = ent[fill_idx].dirty;

    assign fill_taken = fill_taken_load | fill_taken_store | fill_taken_mem;
    assign merge      = miss_wr.en & pend_hit_wr;
    assign alloc_wr   = miss_wr.en & ~pend_hit_wr & any_free;
    // read takes the top free slot, store the bottom one
    assign alloc_rd   = miss_rd.en & any_free & ~(alloc_wr & (free_lo == free_hi));

    // later statements in the loop win, so merge is applied last
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < MSHR_DEPTH; i++) begin
                ent[i] <= '0;
                age[i] <= '0;
            end
        end else begin
            for (int i = 0; i < MSHR_DEPTH; i++) begin
                if (ent[i].valid && age[i] != 8'hff) begin
                    age[i] <= age[i] + 8'd1;
                end
                if (ent[i].valid && ent[i].issued && !ent[i].data_ready &&
                    mem_resp.tag != '0 && mem_resp.tag == ent[i].tag) begin
                    ent[i].data_ready <= 1'b1;
                    // store data already in the entry beats memory data
                    if (ent[i].kind != STORE) begin
                        ent[i].data <= mem_resp.data;
                    end
                end
                if (issue_vld && issue_idx == IDX_BITS'(i)) begin
                    if (ent[i].kind == EVICT) begin
                        ent[i].valid <= 1'b0;
                    end else begin
                        ent[i].issued <= 1'b1;
                        ent[i].tag    <= mem_grant_tag;
                    end
                end
                if (fill_taken && fill_idx == IDX_BITS'(i)) begin
                    // the eviction reuses the slot the fill just left
                    if (miss_evict.en) begin
                        ent[i] <= make_entry(miss_evict);
                        age[i] <= '0;
                    end else begin
                        ent[i].valid <= 1'b0;
                    end
                end
                if (alloc_wr && free_lo == IDX_BITS'(i)) begin
                    ent[i] <= make_entry(miss_wr);
                    age[i] <= '0;
                end
                if (alloc_rd && free_hi == IDX_BITS'(i)) begin
                    ent[i] <= make_entry(miss_rd);
                    age[i] <= '0;
                end
                if (merge && hit_wr[i]) begin
                    ent[i].valid <= 1'b1;
                    ent[i].data  <= store_data;
                    ent[i].dirty <= 1'b1;
                    // a pending eviction stays one and goes out again with the new word
                    if (ent[i].kind != EVICT) begin
                        ent[i].kind <= STORE;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* tb_clock.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 8
) (
    output logic clock,
    output logic rst_n
);

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    // release 1 ns after an edge, like every other input
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        #1;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* tb_dcache.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_dcache;
    import cache_pkg::*;
    import mem_bus_pkg::*;

    localparam int          TIMEOUT_CYCLES = 200;
    localparam int          RANDOM_OPS     = 300;
    localparam logic [31:0] SEED           = 32'h53e7_4e57;

    logic        clock;
    logic        rst_n;
    proc_req_t   proc_req;
    proc_resp_t  proc_resp;
    mem_req_t    mem_req;
    mem_tag_t    mem_grant_tag;
    mem_resp_t   mem_resp;
    logic [15:0] last_store_addr;
    data_word_t  last_store_data;
    int          store_count;
    data_word_t  shadow [logic [15:0]];
    logic [31:0] lcg_state;

    tb_clock #(
        .PERIOD       (8),
        .RESET_CYCLES (8)
    ) u_clock (
        .clock (clock),
        .rst_n (rst_n)
    );

    tb_mem_model #(
        .SEED (SEED)
    ) u_memory (
        .clock           (clock),
        .rst_n           (rst_n),
        .mem_req         (mem_req),
        .mem_grant_tag   (mem_grant_tag),
        .mem_resp        (mem_resp),
        .last_store_addr (last_store_addr),
        .last_store_data (last_store_data),
        .store_count     (store_count)
    );

    dcache_top #(
        .MSHR_DEPTH (4)
    ) uut (
        .clock         (clock),
        .rst_n         (rst_n),
        .proc_req      (proc_req),
        .proc_resp     (proc_resp),
        .mem_req       (mem_req),
        .mem_grant_tag (mem_grant_tag),
        .mem_resp      (mem_resp)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // memory power-up value with the address in all four fields and the top one inverted
    function automatic data_word_t initial_word(input logic [15:0] a);
        return {~a, a, a, a};
    endfunction

    function automatic data_word_t expected_read(input logic [15:0] a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return initial_word(a);
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t ns: %s is %h, expected %h",
                                $time, name, got, exp));
        end
    endtask

    task automatic wait_reset();
        int cycles;
        cycles = 0;
        while (rst_n !== 1'b1) begin
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                abort_run("reset was never released");
            end
            @(posedge clock);
        end
    endtask

    // hold the read until the cache hands back the word
    task automatic read_until_valid(input logic [15:0] addr);
        int cycles;
        cycles = 0;
        @(posedge clock);
        #1;
        proc_req.rd_en   = 1'b1;
        proc_req.rd_addr = addr;
        @(negedge clock);
        while (!proc_resp.valid_data) begin
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                abort_run($sformatf("read of address %h never returned data", addr));
            end
            @(negedge clock);
        end
        @(posedge clock);
        #1;
        proc_req.rd_en = 1'b0;
    endtask

    task automatic store_when_ready(input logic [15:0] addr, input data_word_t data);
        int cycles;
        cycles = 0;
        @(posedge clock);
        #1;
        while (!proc_resp.ready) begin
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                abort_run($sformatf("cache not ready for store to %h in time", addr));
            end
            @(posedge clock);
            #1;
        end
        proc_req.wr_en   = 1'b1;
        proc_req.wr_addr = addr;
        proc_req.wr_data = data;
        shadow[addr]     = data;
        @(posedge clock);
        #1;
        proc_req.wr_en = 1'b0;
    endtask

    // compare every returned read word against the reference
    always @(negedge clock) begin
        if (rst_n && proc_req.rd_en && proc_resp.valid_data) begin
            check_value("proc_resp.data", proc_resp.data, expected_read(proc_req.rd_addr));
        end
    end

    initial begin
        logic [31:0] r;
        logic [15:0] addr;
        data_word_t  word_a;
        int          prev_stores;
        proc_req  = '0;
        lcg_state = SEED;
        wait_reset();

        @(negedge clock);
        check_value("proc_resp.valid_data", 64'(proc_resp.valid_data), 64'd0);
        check_value("proc_resp.ready", 64'(proc_resp.ready), 64'd1);
        check_value("mem_req.cmd", 64'(mem_req.cmd), 64'(BUS_NONE));

        // miss then hit on the same word
        read_until_valid(16'h0041);
        read_until_valid(16'h0041);

        // store hit, then store miss
        read_until_valid(16'h0042);
        store_when_ready(16'h0042, 64'h0123_4567_89ab_cdef);
        read_until_valid(16'h0042);
        store_when_ready(16'h0044, 64'hdead_beef_0bad_f00d);
        read_until_valid(16'h0044);

        // dirty line in set 3 pushed out by a conflicting tag
        word_a = 64'hfeed_0123_c0de_5a5a;
        read_until_valid(16'h0123);
        store_when_ready(16'h0123, word_a);
        prev_stores = store_count;
        read_until_valid(16'h0523);
        read_until_valid(16'h0123);
        check_value("store_count", 64'(store_count - prev_stores), 64'd1);
        check_value("last_store_addr", 64'(last_store_addr), 64'h0123);
        check_value("last_store_data", last_store_data, word_a);

        // 16 tags over sets 0 to 3
        for (int i = 0; i < RANDOM_OPS; i++) begin
            lcg_state = lcg_next(lcg_state);
            r         = lcg_state;
            addr      = {7'b0, r[11:8], 3'b0, r[1:0]};
            if (r[16]) begin
                lcg_state      = lcg_next(lcg_state);
                word_a[63:32]  = lcg_state;
                lcg_state      = lcg_next(lcg_state);
                word_a[31:0]   = lcg_state;
                store_when_ready(addr, word_a);
            end else begin
                read_until_valid(addr);
            end
        end

        @(negedge clock);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* tb_mem_model.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_mem_model #(
    parameter logic [31:0] SEED = 32'h53e7_4e57
) (
    input  logic                   clock,
    input  logic                   rst_n,
    input  mem_bus_pkg::mem_req_t  mem_req,
    output mem_bus_pkg::mem_tag_t  mem_grant_tag,
    output mem_bus_pkg::mem_resp_t mem_resp,
    output logic [15:0]            last_store_addr,
    output cache_pkg::data_word_t  last_store_data,
    output int                     store_count
);
    import cache_pkg::*;
    import mem_bus_pkg::*;

    data_word_t  mem_words [logic [15:0]];
    mem_tag_t    q_tag [$];
    data_word_t  q_data [$];
    int          q_due [$];
    logic [31:0] lcg_state;
    int          cycle;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // unwritten words follow the power-up pattern
    function automatic data_word_t read_word(input logic [15:0] a);
        if (mem_words.exists(a)) begin
            return mem_words[a];
        end
        return {~a, a, a, a};
    endfunction

    initial begin
        int   delay;
        int   idx;
        logic load_seen;
        mem_grant_tag   = 4'd1;
        mem_resp        = '0;
        last_store_addr = '0;
        last_store_data = '0;
        store_count     = 0;
        lcg_state       = SEED;
        cycle           = 0;
        forever begin
            // commands are looked at mid-cycle, where they are stable
            @(negedge clock);
            load_seen = 1'b0;
            if (rst_n && mem_req.cmd == BUS_STORE) begin
                mem_words[mem_req.addr] = mem_req.data;
                last_store_addr         = mem_req.addr;
                last_store_data         = mem_req.data;
                store_count             = store_count + 1;
            end else if (rst_n && mem_req.cmd == BUS_LOAD) begin
                lcg_state = lcg_next(lcg_state);
                delay     = 2 + int'((lcg_state >> 16) % 32'd5);
                q_tag.push_back(mem_grant_tag);
                q_data.push_back(read_word(mem_req.addr));
                q_due.push_back(cycle + delay);
                load_seen = 1'b1;
            end
            @(posedge clock);
            #1;
            cycle = cycle + 1;
            // the granted tag was latched at this edge, move to the next one
            if (load_seen) begin
                mem_grant_tag = (mem_grant_tag == 4'd15) ? 4'd1 : mem_grant_tag + 4'd1;
            end
            mem_resp = '0;
            idx      = -1;
            for (int i = 0; i < q_due.size(); i++) begin
                if (idx < 0 && q_due[i] <= cycle) begin
                    idx = i;
                end
            end
            // one response per cycle, late ones slip
            if (idx >= 0) begin
                mem_resp.tag  = q_tag[idx];
                mem_resp.data = q_data[idx];
                q_tag.delete(idx);
                q_data.delete(idx);
                q_due.delete(idx);
            end
        end
    end

endmodule

`default_nettype wire
